//--- dv/tile_io_stimulus.txt
# op(0 rd, 1 wr) address wdata expected_rdata resp_hold_cycles group
# group: 0 single, 1 queued with resp_ready low, 2 blocked on a full device
0 00200004 00000000 0000005a 0 0
1 00200008 cafef00d 00000000 0 0
0 00200008 00000000 cafef00d 2 0
0 00200000 00000000 00000001 0 0
1 00200000 00000000 00000000 1 0
0 00200000 00000000 00000000 0 0
0 00100008 00000000 ffffffff 0 0
1 00100010 00000001 00000000 0 0
0 00100010 00000000 00000001 0 0
1 00100010 00000000 00000000 0 0
1 00100000 00000000 00000000 0 0
1 00100008 00000014 00000000 0 0
1 00100008 ffffffff 00000000 0 0
0 00300010 00000000 00000000 0 0
0 00000040 00000000 00000000 0 0
0 80001000 00000000 00000000 0 0
1 fffffffc 12345678 00000000 3 0
0 80000100 00000000 00000000 0 1
0 00100008 00000000 ffffffff 0 1
0 00200008 00000000 cafef00d 0 1
0 00200004 00000000 0000005a 0 0
0 00500000 00000000 00000000 0 1
0 00100010 00000000 00000000 0 1
0 00200004 00000000 0000005a 0 1
0 00200000 00000000 00000000 3 2

//--- tile_io.f
design/tile_io_pkg.sv
design/mem_cmd_router.sv
design/mem_resp_arbiter.sv
design/cfg_regs.sv
design/clint_slice.sv
design/loopback_sink.sv
design/tile_io.sv
dv/tile_io_tb.sv

//--- Makefile
# Verilator lint and simulation flow for tile_io
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert --Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --assert
TB_TOP     := tile_io_tb
RTL_TOP    := tile_io
FILELIST   := tile_io.f
LOG        := sim.log
PASS_MSG   := No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -o V$(TB_TOP)
	-./obj_dir/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tile_io_tb.sv
// Testbench for the tile I/O fabric driven by a command file with expected responses
`timescale 1ns/100ps

module tile_io_tb;

  import tile_io_pkg::*;

  localparam int DATA_WIDTH  = DATA_WIDTH_DEF;
  localparam int WAIT_CYCLES = 200;
  localparam logic [DID_WIDTH-1:0] TB_DID = 8'h5a;

  logic                  clk_i;
  logic                  arst_n_i;
  logic [DID_WIDTH-1:0]  did_i;
  logic                  cmd_v_i;
  logic                  cmd_ready_o;
  mem_op_e               cmd_op_i;
  logic [ADDR_WIDTH-1:0] cmd_addr_i;
  logic [DATA_WIDTH-1:0] cmd_data_i;
  logic                  resp_v_o;
  logic                  resp_ready_i;
  mem_op_e               resp_op_o;
  logic [ADDR_WIDTH-1:0] resp_addr_o;
  logic [DATA_WIDTH-1:0] resp_data_o;
  logic                  freeze_o;
  logic                  timer_irq_o;
  logic                  software_irq_o;

  // Commands accepted but not yet answered
  mem_op_e               pend_op[$];
  logic [ADDR_WIDTH-1:0] pend_addr[$];
  logic [DATA_WIDTH-1:0] pend_data[$];
  dev_e                  pend_dev[$];
  logic [DATA_WIDTH-1:0] cur_exp;
  logic                  accepted;
  logic                  cmd_ready_seen;
  logic                  resp_v_seen;

  initial
  begin
    clk_i = 1'b0;
    forever
      #2 clk_i = ~clk_i;
  end

  tile_io #(.DATA_WIDTH(DATA_WIDTH), .DRAM_BASE(DRAM_BASE_DEF)) u_dut
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .did_i(did_i)
     , .cmd_v_i(cmd_v_i), .cmd_ready_o(cmd_ready_o), .cmd_op_i(cmd_op_i)
     , .cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i)
     , .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i), .resp_op_o(resp_op_o)
     , .resp_addr_o(resp_addr_o), .resp_data_o(resp_data_o)
     , .freeze_o(freeze_o), .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
     );

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] actual,
                            input logic [DATA_WIDTH-1:0] expected);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_op(input string name, input mem_op_e actual, input mem_op_e expected);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s is %s, expected %s",
               $time, name, actual.name(), expected.name());
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] actual,
                            input logic [ADDR_WIDTH-1:0] expected);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, name, actual, expected);
      stop_on_error();
    end
  endtask

  // DRAM and unknown local devices land in the sink
  function automatic dev_e target_of(input logic [ADDR_WIDTH-1:0] addr);
    logic [DEV_WIDTH-1:0] field;
    field = addr[DEV_LSB +: DEV_WIDTH];
    if (addr >= DRAM_BASE_DEF)
      return e_dev_loopback;
    else if (field == CFG_DEV_ID)
      return e_dev_cfg;
    else if (field == CLINT_DEV_ID)
      return e_dev_clint;
    return e_dev_loopback;
  endfunction

  function automatic logic level_of(input string name);
    if (name == "freeze_o")
      return freeze_o;
    else if (name == "timer_irq_o")
      return timer_irq_o;
    return software_irq_o;
  endfunction

  // Highest-priority pending device answers first; enum order is the priority
  task automatic take_response();
    int best;
    best = -1;
    foreach (pend_dev[i])
      if ((best < 0) || (pend_dev[i] < pend_dev[best]))
        best = i;
    if (best < 0)
    begin
      $display("Response at %0d ns with no command outstanding", $time);
      stop_on_error();
    end
    check_op("resp_op_o", resp_op_o, pend_op[best]);
    check_addr("resp_addr_o", resp_addr_o, pend_addr[best]);
    check_data("resp_data_o", resp_data_o, pend_data[best]);
    pend_op.delete(best);
    pend_addr.delete(best);
    pend_data.delete(best);
    pend_dev.delete(best);
  endtask

  // Sample both handshakes at the rising edge, return on the falling edge
  task automatic tick();
    @(posedge clk_i);
    cmd_ready_seen = cmd_ready_o;
    resp_v_seen    = resp_v_o;
    if (resp_v_o && resp_ready_i)
      take_response();
    if (cmd_v_i && cmd_ready_o)
    begin
      foreach (pend_dev[i])
        if (pend_dev[i] == target_of(cmd_addr_i))
        begin
          $display("Command to %h accepted at %0d ns while its device held a response",
                   cmd_addr_i, $time);
          stop_on_error();
        end
      pend_op.push_back(cmd_op_i);
      pend_addr.push_back(cmd_addr_i);
      pend_data.push_back(cur_exp);
      pend_dev.push_back(target_of(cmd_addr_i));
      accepted = 1'b1;
    end
    @(negedge clk_i);
  endtask

  task automatic drive_cmd(input mem_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] wdata,
                           input logic [DATA_WIDTH-1:0] expected);
    cmd_v_i    = 1'b1;
    cmd_op_i   = op;
    cmd_addr_i = addr;
    cmd_data_i = wdata;
    cur_exp    = expected;
    accepted   = 1'b0;
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    while (!accepted)
    begin
      if (n == WAIT_CYCLES)
      begin
        $display("Timeout: command to %h was never accepted", cmd_addr_i);
        stop_on_error();
      end
      tick();
      n++;
    end
    cmd_v_i = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    resp_ready_i = 1'b1;
    while (pend_dev.size() != 0)
    begin
      if (n == WAIT_CYCLES)
      begin
        $display("Timeout: %0d responses never arrived", pend_dev.size());
        stop_on_error();
      end
      tick();
      n++;
    end
  endtask

  task automatic wait_level(input string name, input logic expected);
    int n;
    n = 0;
    while ((level_of(name) !== expected) && (n < WAIT_CYCLES))
    begin
      tick();
      n++;
    end
    check_bit(name, level_of(name), expected);
  endtask

  task automatic check_write_effect(input mem_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                                    input logic [DATA_WIDTH-1:0] wdata);
    dev_e                 dev;
    logic [REG_WIDTH-1:0] ofs;
    dev = target_of(addr);
    ofs = addr[REG_WIDTH-1:0];
    if (op == e_mem_wr)
    begin
      if ((dev == e_dev_cfg) && (ofs == CFG_FREEZE_OFS))
        wait_level("freeze_o", wdata[0]);
      else if ((dev == e_dev_clint) && (ofs == CLINT_MSIP_OFS))
        wait_level("software_irq_o", wdata[0]);
      else if ((dev == e_dev_clint) && (ofs == CLINT_MTIMECMP_OFS))
        wait_level("timer_irq_o", wdata != '1);
    end
  endtask

  // Group 0 single command, 1 queued under back-pressure, 2 blocked on a full device
  task automatic run_line(input mem_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] wdata,
                          input logic [DATA_WIDTH-1:0] expected,
                          input int hold, input int group);
    if (group == 0)
    begin
      if (pend_dev.size() != 0)
        drain();
      resp_ready_i = (hold == 0);
      drive_cmd(op, addr, wdata, expected);
      wait_accept();
      // Idle fabric answers one cycle after the command transfer
      tick();
      check_bit("resp_v_o", resp_v_seen, 1'b1);
      if (hold > 1)
      begin
        repeat (hold - 1)
          tick();
      end
      drain();
      check_write_effect(op, addr, wdata);
    end
    else if (group == 1)
    begin
      resp_ready_i = 1'b0;
      drive_cmd(op, addr, wdata, expected);
      // Target device is empty, so no wait state is allowed
      tick();
      check_bit("cmd_ready_o", cmd_ready_seen, 1'b1);
      wait_accept();
    end
    else
    begin
      resp_ready_i = 1'b0;
      drive_cmd(op, addr, wdata, expected);
      repeat (hold)
      begin
        tick();
        check_bit("cmd_ready_o", cmd_ready_seen, 1'b0);
      end
      resp_ready_i = 1'b1;
      wait_accept();
      drain();
    end
  endtask

  initial
  begin
    int                    fd;
    int                    n;
    int                    opv;
    int                    hold;
    int                    group;
    string                 line;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH-1:0] expected;
    arst_n_i       = 1'b0;
    did_i          = TB_DID;
    cmd_v_i        = 1'b0;
    cmd_op_i       = e_mem_rd;
    cmd_addr_i     = '0;
    cmd_data_i     = '0;
    resp_ready_i   = 1'b1;
    cur_exp        = '0;
    accepted       = 1'b0;
    cmd_ready_seen = 1'b0;
    resp_v_seen    = 1'b0;
    repeat (5)
      @(negedge clk_i);
    arst_n_i = 1'b1;
    tick();
    check_bit("freeze_o", freeze_o, 1'b1);
    check_bit("timer_irq_o", timer_irq_o, 1'b0);
    check_bit("software_irq_o", software_irq_o, 1'b0);
    check_bit("resp_v_o", resp_v_o, 1'b0);
    check_bit("cmd_ready_o", cmd_ready_o, 1'b1);

    fd = $fopen("dv/tile_io_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file dv/tile_io_stimulus.txt");
      stop_on_error();
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if ((line.len() < 2) || (line[0] == "#"))
        continue;
      n = $sscanf(line, "%h %h %h %h %d %d", opv, addr, wdata, expected, hold, group);
      if (n != 6)
      begin
        $display("Malformed stimulus line: %s", line);
        stop_on_error();
      end
      run_line(mem_op_e'(opv[0]), addr, wdata, expected, hold, group);
    end
    $fclose(fd);
    drain();
    $display("No errors");
    $finish;
  end

endmodule

//--- design/tile_io.sv
// Tile local I/O top with command router, three devices and response arbiter
`timescale 1ns/100ps

module tile_io
  #(parameter int DATA_WIDTH = tile_io_pkg::DATA_WIDTH_DEF
    , parameter logic [tile_io_pkg::ADDR_WIDTH-1:0] DRAM_BASE = tile_io_pkg::DRAM_BASE_DEF
    )
  (input  logic                                 clk_i
   , input  logic                               arst_n_i
   , input  logic [tile_io_pkg::DID_WIDTH-1:0]  did_i
   , input  logic                               cmd_v_i
   , output logic                               cmd_ready_o
   , input  tile_io_pkg::mem_op_e               cmd_op_i
   , input  logic [tile_io_pkg::ADDR_WIDTH-1:0] cmd_addr_i
   , input  logic [DATA_WIDTH-1:0]              cmd_data_i
   , output logic                               resp_v_o
   , input  logic                               resp_ready_i
   , output tile_io_pkg::mem_op_e               resp_op_o
   , output logic [tile_io_pkg::ADDR_WIDTH-1:0] resp_addr_o
   , output logic [DATA_WIDTH-1:0]              resp_data_o
   , output logic                               freeze_o
   , output logic                               timer_irq_o
   , output logic                               software_irq_o
   );

  import tile_io_pkg::*;

  logic                  cfg_v, cfg_ready;
  logic                  clint_v, clint_ready;
  logic                  lb_v, lb_ready;

  logic                  cfg_resp_v, cfg_resp_ready;
  mem_op_e               cfg_resp_op;
  logic [REG_WIDTH-1:0]  cfg_resp_ofs;
  logic [DATA_WIDTH-1:0] cfg_resp_data;

  logic                  clint_resp_v, clint_resp_ready;
  mem_op_e               clint_resp_op;
  logic [REG_WIDTH-1:0]  clint_resp_ofs;
  logic [DATA_WIDTH-1:0] clint_resp_data;

  logic                  lb_resp_v, lb_resp_ready;
  mem_op_e               lb_resp_op;
  logic [ADDR_WIDTH-1:0] lb_resp_addr;
  logic [DATA_WIDTH-1:0] lb_resp_data;

  mem_cmd_router #(.DRAM_BASE(DRAM_BASE)) u_router
    (.cmd_v_i(cmd_v_i), .cmd_addr_i(cmd_addr_i), .cmd_ready_o(cmd_ready_o)
     , .cfg_v_o(cfg_v), .cfg_ready_i(cfg_ready)
     , .clint_v_o(clint_v), .clint_ready_i(clint_ready)
     , .lb_v_o(lb_v), .lb_ready_i(lb_ready)
     );

  // Op, offset and data are broadcast; only the valid is steered
  cfg_regs #(.DATA_WIDTH(DATA_WIDTH)) u_cfg
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .did_i(did_i)
     , .cmd_v_i(cfg_v), .cmd_ready_o(cfg_ready), .cmd_op_i(cmd_op_i)
     , .cmd_ofs_i(cmd_addr_i[REG_WIDTH-1:0]), .cmd_data_i(cmd_data_i)
     , .resp_v_o(cfg_resp_v), .resp_ready_i(cfg_resp_ready), .resp_op_o(cfg_resp_op)
     , .resp_ofs_o(cfg_resp_ofs), .resp_data_o(cfg_resp_data), .freeze_o(freeze_o)
     );

  clint_slice #(.DATA_WIDTH(DATA_WIDTH)) u_clint
    (.clk_i(clk_i), .arst_n_i(arst_n_i)
     , .cmd_v_i(clint_v), .cmd_ready_o(clint_ready), .cmd_op_i(cmd_op_i)
     , .cmd_ofs_i(cmd_addr_i[REG_WIDTH-1:0]), .cmd_data_i(cmd_data_i)
     , .resp_v_o(clint_resp_v), .resp_ready_i(clint_resp_ready)
     , .resp_op_o(clint_resp_op), .resp_ofs_o(clint_resp_ofs)
     , .resp_data_o(clint_resp_data)
     , .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
     );

  loopback_sink #(.DATA_WIDTH(DATA_WIDTH)) u_loopback
    (.clk_i(clk_i), .arst_n_i(arst_n_i)
     , .cmd_v_i(lb_v), .cmd_ready_o(lb_ready), .cmd_op_i(cmd_op_i), .cmd_addr_i(cmd_addr_i)
     , .resp_v_o(lb_resp_v), .resp_ready_i(lb_resp_ready), .resp_op_o(lb_resp_op)
     , .resp_addr_o(lb_resp_addr), .resp_data_o(lb_resp_data)
     );

  mem_resp_arbiter #(.DATA_WIDTH(DATA_WIDTH)) u_arbiter
    (.cfg_resp_v_i(cfg_resp_v), .cfg_resp_op_i(cfg_resp_op)
     , .cfg_resp_ofs_i(cfg_resp_ofs), .cfg_resp_data_i(cfg_resp_data)
     , .cfg_resp_ready_o(cfg_resp_ready)
     , .clint_resp_v_i(clint_resp_v), .clint_resp_op_i(clint_resp_op)
     , .clint_resp_ofs_i(clint_resp_ofs), .clint_resp_data_i(clint_resp_data)
     , .clint_resp_ready_o(clint_resp_ready)
     , .lb_resp_v_i(lb_resp_v), .lb_resp_op_i(lb_resp_op)
     , .lb_resp_addr_i(lb_resp_addr), .lb_resp_data_i(lb_resp_data)
     , .lb_resp_ready_o(lb_resp_ready)
     , .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i), .resp_op_o(resp_op_o)
     , .resp_addr_o(resp_addr_o), .resp_data_o(resp_data_o)
     );

endmodule

//--- design/loopback_sink.sv
// Loopback sink answering unmapped and DRAM commands with zero data
`timescale 1ns/100ps

module loopback_sink
  #(parameter int DATA_WIDTH = tile_io_pkg::DATA_WIDTH_DEF)
  (input  logic                                 clk_i
   , input  logic                               arst_n_i
   , input  logic                               cmd_v_i
   , output logic                               cmd_ready_o
   , input  tile_io_pkg::mem_op_e               cmd_op_i
   , input  logic [tile_io_pkg::ADDR_WIDTH-1:0] cmd_addr_i
   , output logic                               resp_v_o
   , input  logic                               resp_ready_i
   , output tile_io_pkg::mem_op_e               resp_op_o
   , output logic [tile_io_pkg::ADDR_WIDTH-1:0] resp_addr_o
   , output logic [DATA_WIDTH-1:0]              resp_data_o
   );

  import tile_io_pkg::*;

  logic                  resp_v_q;
  mem_op_e               resp_op_q;
  logic [ADDR_WIDTH-1:0] resp_addr_q;
  logic                  cmd_fire;

  assign cmd_ready_o = ~resp_v_q;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (cmd_fire)
      resp_v_q <= 1'b1;
    else if (resp_ready_i)
      resp_v_q <= 1'b0;
  end

  // Full address is kept since these targets have no device code
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_op_q   <= cmd_op_i;
      resp_addr_q <= cmd_addr_i;
    end
  end

  assign resp_v_o    = resp_v_q;
  assign resp_op_o   = resp_op_q;
  assign resp_addr_o = resp_addr_q;
  assign resp_data_o = '0;

endmodule

//--- design/clint_slice.sv
// Core-local interrupt slice with timer, timer compare and software interrupt
`timescale 1ns/100ps

module clint_slice
  #(parameter int DATA_WIDTH = tile_io_pkg::DATA_WIDTH_DEF)
  (input  logic                                clk_i
   , input  logic                              arst_n_i
   , input  logic                              cmd_v_i
   , output logic                              cmd_ready_o
   , input  tile_io_pkg::mem_op_e              cmd_op_i
   , input  logic [tile_io_pkg::REG_WIDTH-1:0] cmd_ofs_i
   , input  logic [DATA_WIDTH-1:0]             cmd_data_i
   , output logic                              resp_v_o
   , input  logic                              resp_ready_i
   , output tile_io_pkg::mem_op_e              resp_op_o
   , output logic [tile_io_pkg::REG_WIDTH-1:0] resp_ofs_o
   , output logic [DATA_WIDTH-1:0]             resp_data_o
   , output logic                              timer_irq_o
   , output logic                              software_irq_o
   );

  import tile_io_pkg::*;

  logic [DATA_WIDTH-1:0] mtime_q;
  logic [DATA_WIDTH-1:0] mtimecmp_q;
  logic                  msip_q;
  logic                  timer_irq_q;
  logic                  software_irq_q;
  logic                  resp_v_q;
  mem_op_e               resp_op_q;
  logic [REG_WIDTH-1:0]  resp_ofs_q;
  logic [DATA_WIDTH-1:0] resp_data_q;
  logic                  cmd_fire;
  logic                  wr_fire;
  logic [DATA_WIDTH-1:0] rd_data;

  assign cmd_ready_o = ~resp_v_q;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign wr_fire     = cmd_fire & (cmd_op_i == e_mem_wr);

  always_comb
  begin
    case (cmd_ofs_i)
      CLINT_MTIME_OFS:    rd_data = mtime_q;
      CLINT_MTIMECMP_OFS: rd_data = mtimecmp_q;
      CLINT_MSIP_OFS:     rd_data = DATA_WIDTH'(msip_q);
      default:            rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_q       <= 1'b0;
      mtime_q        <= '0;
      mtimecmp_q     <= '1;
      msip_q         <= 1'b0;
      timer_irq_q    <= 1'b0;
      software_irq_q <= 1'b0;
    end
    else
    begin
      if (cmd_fire)
        resp_v_q <= 1'b1;
      else if (resp_ready_i)
        resp_v_q <= 1'b0;
      // A write to mtime replaces this cycle's increment
      if (wr_fire && (cmd_ofs_i == CLINT_MTIME_OFS))
        mtime_q <= cmd_data_i;
      else
        mtime_q <= mtime_q + DATA_WIDTH'(1);
      if (wr_fire && (cmd_ofs_i == CLINT_MTIMECMP_OFS))
        mtimecmp_q <= cmd_data_i;
      if (wr_fire && (cmd_ofs_i == CLINT_MSIP_OFS))
        msip_q <= cmd_data_i[0];
      timer_irq_q    <= (mtime_q >= mtimecmp_q);
      software_irq_q <= msip_q;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_op_q   <= cmd_op_i;
      resp_ofs_q  <= cmd_ofs_i;
      resp_data_q <= (cmd_op_i == e_mem_rd) ? rd_data : '0;
    end
  end

  assign resp_v_o       = resp_v_q;
  assign resp_op_o      = resp_op_q;
  assign resp_ofs_o     = resp_ofs_q;
  assign resp_data_o    = resp_data_q;
  assign timer_irq_o    = timer_irq_q;
  assign software_irq_o = software_irq_q;

  // Irq lags the compare by one cycle; mtime at all ones still matches
  a_cmp_disabled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mtimecmp_q == '1) && (mtime_q != '1) |=> !timer_irq_o);

endmodule

//--- design/cfg_regs.sv
// Configuration register device with freeze, device id and scratch registers
`timescale 1ns/100ps

module cfg_regs
  #(parameter int DATA_WIDTH = tile_io_pkg::DATA_WIDTH_DEF)
  (input  logic                                clk_i
   , input  logic                              arst_n_i
   , input  logic [tile_io_pkg::DID_WIDTH-1:0] did_i
   , input  logic                              cmd_v_i
   , output logic                              cmd_ready_o
   , input  tile_io_pkg::mem_op_e              cmd_op_i
   , input  logic [tile_io_pkg::REG_WIDTH-1:0] cmd_ofs_i
   , input  logic [DATA_WIDTH-1:0]             cmd_data_i
   , output logic                              resp_v_o
   , input  logic                              resp_ready_i
   , output tile_io_pkg::mem_op_e              resp_op_o
   , output logic [tile_io_pkg::REG_WIDTH-1:0] resp_ofs_o
   , output logic [DATA_WIDTH-1:0]             resp_data_o
   , output logic                              freeze_o
   );

  import tile_io_pkg::*;

  logic                  freeze_q;
  logic [DATA_WIDTH-1:0] scratch_q;
  logic                  resp_v_q;
  mem_op_e               resp_op_q;
  logic [REG_WIDTH-1:0]  resp_ofs_q;
  logic [DATA_WIDTH-1:0] resp_data_q;
  logic                  cmd_fire;
  logic                  wr_fire;
  logic [DATA_WIDTH-1:0] rd_data;

  // One response slot, so ready only while it is empty
  assign cmd_ready_o = ~resp_v_q;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign wr_fire     = cmd_fire & (cmd_op_i == e_mem_wr);

  always_comb
  begin
    case (cmd_ofs_i)
      CFG_FREEZE_OFS:  rd_data = DATA_WIDTH'(freeze_q);
      CFG_DID_OFS:     rd_data = DATA_WIDTH'(did_i);
      CFG_SCRATCH_OFS: rd_data = scratch_q;
      default:         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_q  <= 1'b0;
      freeze_q  <= 1'b1;
      scratch_q <= '0;
    end
    else
    begin
      if (cmd_fire)
        resp_v_q <= 1'b1;
      else if (resp_ready_i)
        resp_v_q <= 1'b0;
      if (wr_fire && (cmd_ofs_i == CFG_FREEZE_OFS))
        freeze_q <= cmd_data_i[0];
      if (wr_fire && (cmd_ofs_i == CFG_SCRATCH_OFS))
        scratch_q <= cmd_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_op_q   <= cmd_op_i;
      resp_ofs_q  <= cmd_ofs_i;
      resp_data_q <= (cmd_op_i == e_mem_rd) ? rd_data : '0;
    end
  end

  assign resp_v_o    = resp_v_q;
  assign resp_op_o   = resp_op_q;
  assign resp_ofs_o  = resp_ofs_q;
  assign resp_data_o = resp_data_q;
  assign freeze_o    = freeze_q;

  // Stalled response must not change under the arbiter
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_op_o)
      && $stable(resp_ofs_o) && $stable(resp_data_o));

endmodule

//--- design/mem_resp_arbiter.sv
// Fixed-priority response arbiter merging device responses onto one channel
`timescale 1ns/100ps

module mem_resp_arbiter
  #(parameter int DATA_WIDTH = tile_io_pkg::DATA_WIDTH_DEF)
  (input  logic                                 cfg_resp_v_i
   , input  tile_io_pkg::mem_op_e               cfg_resp_op_i
   , input  logic [tile_io_pkg::REG_WIDTH-1:0]  cfg_resp_ofs_i
   , input  logic [DATA_WIDTH-1:0]              cfg_resp_data_i
   , output logic                               cfg_resp_ready_o
   , input  logic                               clint_resp_v_i
   , input  tile_io_pkg::mem_op_e               clint_resp_op_i
   , input  logic [tile_io_pkg::REG_WIDTH-1:0]  clint_resp_ofs_i
   , input  logic [DATA_WIDTH-1:0]              clint_resp_data_i
   , output logic                               clint_resp_ready_o
   , input  logic                               lb_resp_v_i
   , input  tile_io_pkg::mem_op_e               lb_resp_op_i
   , input  logic [tile_io_pkg::ADDR_WIDTH-1:0] lb_resp_addr_i
   , input  logic [DATA_WIDTH-1:0]              lb_resp_data_i
   , output logic                               lb_resp_ready_o
   , output logic                               resp_v_o
   , input  logic                               resp_ready_i
   , output tile_io_pkg::mem_op_e               resp_op_o
   , output logic [tile_io_pkg::ADDR_WIDTH-1:0] resp_addr_o
   , output logic [DATA_WIDTH-1:0]              resp_data_o
   );

  import tile_io_pkg::*;

  dev_e       gnt_dev;
  logic [2:0] gnt;

  // Local address from device code and register offset
  function automatic logic [ADDR_WIDTH-1:0] local_addr
    (input logic [DEV_WIDTH-1:0] dev
     , input logic [REG_WIDTH-1:0] ofs
     );
    logic [ADDR_WIDTH-1:0] addr;
    addr = '0;
    addr[DEV_LSB +: DEV_WIDTH] = dev;
    addr[REG_WIDTH-1:0] = ofs;
    return addr;
  endfunction

  // cfg wins over clint, clint over loopback
  always_comb
  begin
    gnt     = '0;
    gnt_dev = e_dev_loopback;
    if (cfg_resp_v_i)
    begin
      gnt_dev        = e_dev_cfg;
      gnt[e_dev_cfg] = 1'b1;
    end
    else if (clint_resp_v_i)
    begin
      gnt_dev          = e_dev_clint;
      gnt[e_dev_clint] = 1'b1;
    end
    else if (lb_resp_v_i)
    begin
      gnt[e_dev_loopback] = 1'b1;
    end
  end

  always_comb
  begin
    case (gnt_dev)
      e_dev_cfg:
      begin
        resp_op_o   = cfg_resp_op_i;
        resp_addr_o = local_addr(CFG_DEV_ID, cfg_resp_ofs_i);
        resp_data_o = cfg_resp_data_i;
      end
      e_dev_clint:
      begin
        resp_op_o   = clint_resp_op_i;
        resp_addr_o = local_addr(CLINT_DEV_ID, clint_resp_ofs_i);
        resp_data_o = clint_resp_data_i;
      end
      default:
      begin
        resp_op_o   = lb_resp_op_i;
        resp_addr_o = lb_resp_addr_i;
        resp_data_o = lb_resp_data_i;
      end
    endcase
  end

  assign resp_v_o           = |gnt;
  assign cfg_resp_ready_o   = gnt[e_dev_cfg] & resp_ready_i;
  assign clint_resp_ready_o = gnt[e_dev_clint] & resp_ready_i;
  assign lb_resp_ready_o    = gnt[e_dev_loopback] & resp_ready_i;

  always_comb
  begin
    assert ($onehot0(gnt))
      else $error("response grant is not one-hot");
  end

endmodule

//--- design/mem_cmd_router.sv
// Command router that decodes the address and steers valid/ready to one device
`timescale 1ns/100ps

module mem_cmd_router
  #(parameter logic [tile_io_pkg::ADDR_WIDTH-1:0] DRAM_BASE = tile_io_pkg::DRAM_BASE_DEF)
  (input  logic                              cmd_v_i
   , input  logic [tile_io_pkg::ADDR_WIDTH-1:0] cmd_addr_i
   , output logic                            cmd_ready_o
   , output logic                            cfg_v_o
   , input  logic                            cfg_ready_i
   , output logic                            clint_v_o
   , input  logic                            clint_ready_i
   , output logic                            lb_v_o
   , input  logic                            lb_ready_i
   );

  import tile_io_pkg::*;

  logic                 is_local;
  logic [DEV_WIDTH-1:0] dev_field;
  dev_e                 target;

  assign is_local  = (cmd_addr_i < DRAM_BASE);
  assign dev_field = cmd_addr_i[DEV_LSB +: DEV_WIDTH];

  // DRAM and unknown local devices both end up in the loopback sink
  always_comb
  begin
    target = e_dev_loopback;
    if (is_local && (dev_field == CFG_DEV_ID))
      target = e_dev_cfg;
    else if (is_local && (dev_field == CLINT_DEV_ID))
      target = e_dev_clint;
  end

  always_comb
  begin
    case (target)
      e_dev_cfg:   cmd_ready_o = cfg_ready_i;
      e_dev_clint: cmd_ready_o = clint_ready_i;
      default:     cmd_ready_o = lb_ready_i;
    endcase
  end

  assign cfg_v_o   = cmd_v_i & cfg_ready_i & (target == e_dev_cfg);
  assign clint_v_o = cmd_v_i & clint_ready_i & (target == e_dev_clint);
  assign lb_v_o    = cmd_v_i & lb_ready_i & (target == e_dev_loopback);

  always_comb
  begin
    assert ($onehot0({cfg_v_o, clint_v_o, lb_v_o}))
      else $error("router raised more than one device valid");
  end

endmodule

//--- design/tile_io_pkg.sv
// Tile I/O package with opcodes, device codes, address map and register offsets
package tile_io_pkg;

  typedef enum logic
  {
    e_mem_rd = 1'b0
    , e_mem_wr = 1'b1
  } mem_op_e;

  typedef enum logic [1:0]
  {
    e_dev_cfg        = 2'd0
    , e_dev_clint    = 2'd1
    , e_dev_loopback = 2'd2
  } dev_e;

  localparam int ADDR_WIDTH     = 32;
  localparam int DATA_WIDTH_DEF = 32;
  localparam int DID_WIDTH      = 8;

  // Everything at or above this is DRAM
  localparam logic [ADDR_WIDTH-1:0] DRAM_BASE_DEF = 32'h8000_0000;

  // Local address layout
  localparam int DEV_LSB   = 20;
  localparam int DEV_WIDTH = 4;
  localparam int REG_WIDTH = 8;

  localparam logic [DEV_WIDTH-1:0] CLINT_DEV_ID = 4'd1;
  localparam logic [DEV_WIDTH-1:0] CFG_DEV_ID   = 4'd2;

  // Config block offsets
  localparam logic [REG_WIDTH-1:0] CFG_FREEZE_OFS  = 8'h00;
  localparam logic [REG_WIDTH-1:0] CFG_DID_OFS     = 8'h04;
  localparam logic [REG_WIDTH-1:0] CFG_SCRATCH_OFS = 8'h08;

  // Interrupt slice offsets
  localparam logic [REG_WIDTH-1:0] CLINT_MTIME_OFS    = 8'h00;
  localparam logic [REG_WIDTH-1:0] CLINT_MTIMECMP_OFS = 8'h08;
  localparam logic [REG_WIDTH-1:0] CLINT_MSIP_OFS     = 8'h10;

endpackage
